// ==== design/memSysPkg.sv ====
package memSysPkg;

    // ************************************************************
    // Widths
    // ************************************************************

    // Default RAM address width
    localparam int AddrW = 17;

    // Request address field, wide enough for the largest supported RAM
    localparam int AddrMaxW = 20;

    localparam int WordW = 32;

    // ************************************************************
    // Access codes
    // ************************************************************

    // Encoded value equals the byte count
    typedef enum logic [2:0] {
        Len1 = 3'd1,
        Len2 = 3'd2,
        Len4 = 3'd4
    } accLen_t;

    typedef enum logic [1:0] {
        OpFetch = 2'd0,
        OpLoad  = 2'd1,
        OpStore = 2'd2
    } memOp_t;

    // ************************************************************
    // Request passed from arbiter to sequencer
    // ************************************************************

    typedef struct packed {
        memOp_t                op;
        accLen_t               len;
        logic [AddrMaxW-1:0]   addr;
        // Store data, ignored for fetch and load
        logic [WordW-1:0]      data;
    } memReq_t;

endpackage

// ==== design/byteRam.sv ====
`timescale 1ns/1ps

module byteRam import memSysPkg::*; #(
    parameter int AddrBits = AddrW
) (
    input  logic                clk,
    input  logic [AddrBits-1:0] i_addr,
    input  logic                i_we,
    input  logic [7:0]          i_wr,
    output logic [7:0]          o_rd
);

    localparam int Depth = 1 << AddrBits;

    logic [7:0] mem [Depth];

    // Memory starts cleared
    initial begin
        for (int i = 0; i < Depth; i++) begin
            mem[i] = 8'h00;
        end
    end

    // Read during write gives the old byte
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wr;
        end
        o_rd <= mem[i_addr];
    end

endmodule

// ==== design/memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter import memSysPkg::*; #(
    parameter int AddrBits = AddrW
) (
    input  logic                clk,
    input  logic                i_rstN,
    input  logic                i_flush,
    input  logic                i_fetchEn,
    input  logic [AddrBits-1:0] i_fetchAddr,
    input  logic                i_dataEn,
    input  logic                i_dataStore,
    input  accLen_t             i_dataLen,
    input  logic [AddrBits-1:0] i_dataAddr,
    input  logic [WordW-1:0]    i_dataWr,
    input  logic                i_seqBusy,
    input  logic                i_fetchDone,
    input  logic                i_dataDone,
    output logic                o_grantValid,
    output memReq_t             o_grantReq
);

    logic    fetchServed;
    logic    dataServed;
    logic    fetchReq;
    logic    dataReq;
    logic    canPick;
    logic    dropFetch;
    memReq_t fetchReqS;
    memReq_t dataReqS;

    // Fetches are always whole instruction words
    assign fetchReqS = '{op: OpFetch, len: Len4, addr: AddrMaxW'(i_fetchAddr), data: '0};
    assign dataReqS  = '{op: i_dataStore ? OpStore : OpLoad, len: i_dataLen,
                         addr: AddrMaxW'(i_dataAddr), data: i_dataWr};

    // A held enable counts only once until its done
    assign dataReq   = i_dataEn && !dataServed;
    assign fetchReq  = i_fetchEn && !fetchServed && !i_flush;
    assign canPick   = !i_seqBusy && !o_grantValid;
    assign dropFetch = i_flush && (o_grantReq.op == OpFetch);

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            o_grantValid <= 1'b0;
            fetchServed  <= 1'b0;
            dataServed   <= 1'b0;
        end else begin
            if (canPick && dataReq) begin
                o_grantValid <= 1'b1;
                dataServed   <= 1'b1;
            end else if (canPick && fetchReq) begin
                o_grantValid <= 1'b1;
                fetchServed  <= 1'b1;
            end else if (o_grantValid && (!i_seqBusy || dropFetch)) begin
                o_grantValid <= 1'b0;
            end
            if (i_dataDone) dataServed <= 1'b0;
            if (i_fetchDone || i_flush) fetchServed <= 1'b0;
        end
    end

    // Data side has fixed priority
    always_ff @(posedge clk) begin
        if (canPick) begin
            o_grantReq <= dataReq ? dataReqS : fetchReqS;
        end
    end

endmodule

// ==== design/byteSequencer.sv ====
`timescale 1ns/1ps

module byteSequencer import memSysPkg::*; #(
    parameter int AddrBits = AddrW
) (
    input  logic                clk,
    input  logic                i_rstN,
    input  logic                i_flush,
    input  logic                i_ioStall,
    input  logic                i_grantValid,
    input  memReq_t             i_grantReq,
    input  logic [7:0]          i_ramRd,
    output logic                o_busy,
    output logic [AddrBits-1:0] o_ramAddr,
    output logic                o_ramWe,
    output logic [7:0]          o_ramWr,
    output logic                o_fetchDone,
    output logic [WordW-1:0]    o_fetchInst,
    output logic                o_dataDone,
    output logic [WordW-1:0]    o_dataRd
);

    // ************************************************************
    // Operation state
    // ************************************************************

    logic                active;
    memOp_t              curOp;
    accLen_t             curLen;
    logic [AddrBits-1:0] baseAddr;
    logic [WordW-1:0]    storeData;
    logic [2:0]          stage;
    logic [WordW-1:0]    partial;

    logic                accept;
    logic                isRead;
    logic                lastStage;
    logic                flushFetch;
    logic [2:0]          byteCount;
    logic [2:0]          addrOff;
    logic [5:0]          rdShift;
    logic [WordW-1:0]    assembled;

    assign accept = !active && i_grantValid && !i_ioStall
                    && !(i_flush && (i_grantReq.op == OpFetch));

    assign isRead     = (curOp != OpStore);
    assign byteCount  = curLen;
    assign flushFetch = i_flush && (curOp == OpFetch);

    // Reads finish one stage later because of the RAM latency
    assign lastStage = isRead ? (stage == byteCount) : (stage + 3'd1 == byteCount);

    assign o_busy = active || i_ioStall;

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            active <= 1'b0;
            stage  <= 3'd0;
        end else if (!active) begin
            if (accept) begin
                active <= 1'b1;
                stage  <= 3'd0;
            end
        end else if (flushFetch) begin
            active <= 1'b0;
            stage  <= 3'd0;
        end else if (!i_ioStall) begin
            if (lastStage) begin
                active <= 1'b0;
                stage  <= 3'd0;
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            curOp     <= i_grantReq.op;
            curLen    <= i_grantReq.len;
            baseAddr  <= i_grantReq.addr[AddrBits-1:0];
            storeData <= i_grantReq.data;
            partial   <= '0;
        end else if (active && isRead && !i_ioStall && stage != 3'd0) begin
            partial <= assembled;
        end
    end

    // ************************************************************
    // RAM side
    // ************************************************************

    // While stalled, keep reading the byte still owed so it is
    // on the RAM output again when the stall lifts
    assign addrOff = (i_ioStall && isRead && stage != 3'd0) ? stage - 3'd1 : stage;

    assign o_ramAddr = baseAddr + AddrBits'(addrOff);
    assign o_ramWe   = active && !isRead && !i_ioStall;
    assign o_ramWr   = storeData[{stage[1:0], 3'b000} +: 8];

    // ************************************************************
    // Result assembly
    // ************************************************************

    // Returned byte belongs to the previous stage, little-endian
    assign rdShift   = {stage - 3'd1, 3'b000};
    assign assembled = partial | (WordW'(i_ramRd) << rdShift);

    assign o_fetchDone = active && lastStage && (curOp == OpFetch) && !i_ioStall && !i_flush;
    assign o_dataDone  = active && lastStage && (curOp != OpFetch) && !i_ioStall;
    assign o_fetchInst = assembled;
    assign o_dataRd    = assembled;

endmodule

// ==== design/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem import memSysPkg::*; #(
    parameter int AddrBits = AddrW
) (
    input  logic                clk,
    input  logic                i_rstN,
    input  logic                i_fetchEn,
    input  logic [AddrBits-1:0] i_fetchAddr,
    input  logic                i_dataEn,
    input  logic                i_dataStore,
    input  accLen_t             i_dataLen,
    input  logic [AddrBits-1:0] i_dataAddr,
    input  logic [WordW-1:0]    i_dataWr,
    input  logic                i_flush,
    input  logic                i_ioStall,
    output logic                o_fetchDone,
    output logic [WordW-1:0]    o_fetchInst,
    output logic                o_dataDone,
    output logic [WordW-1:0]    o_dataRd
);

    memReq_t             grantReq;
    logic                grantValid;
    logic                seqBusy;
    logic [AddrBits-1:0] ramAddr;
    logic                ramWe;
    logic [7:0]          ramWr;
    logic [7:0]          ramRd;

    memArbiter #(.AddrBits(AddrBits)) u_arbiter (
        .clk          (clk),
        .i_rstN       (i_rstN),
        .i_flush      (i_flush),
        .i_fetchEn    (i_fetchEn),
        .i_fetchAddr  (i_fetchAddr),
        .i_dataEn     (i_dataEn),
        .i_dataStore  (i_dataStore),
        .i_dataLen    (i_dataLen),
        .i_dataAddr   (i_dataAddr),
        .i_dataWr     (i_dataWr),
        .i_seqBusy    (seqBusy),
        .i_fetchDone  (o_fetchDone),
        .i_dataDone   (o_dataDone),
        .o_grantValid (grantValid),
        .o_grantReq   (grantReq)
    );

    byteSequencer #(.AddrBits(AddrBits)) u_sequencer (
        .clk          (clk),
        .i_rstN       (i_rstN),
        .i_flush      (i_flush),
        .i_ioStall    (i_ioStall),
        .i_grantValid (grantValid),
        .i_grantReq   (grantReq),
        .i_ramRd      (ramRd),
        .o_busy       (seqBusy),
        .o_ramAddr    (ramAddr),
        .o_ramWe      (ramWe),
        .o_ramWr      (ramWr),
        .o_fetchDone  (o_fetchDone),
        .o_fetchInst  (o_fetchInst),
        .o_dataDone   (o_dataDone),
        .o_dataRd     (o_dataRd)
    );

    byteRam #(.AddrBits(AddrBits)) u_ram (
        .clk    (clk),
        .i_addr (ramAddr),
        .i_we   (ramWe),
        .i_wr   (ramWr),
        .o_rd   (ramRd)
    );

endmodule

// ==== testbench/tbModel.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ************************************************************
// Random source and error count
// ************************************************************

logic [31:0] lfsrState  = 32'hae978b3b;
int          errorCount = 0;

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value[i]  = lfsrState[0];
        lfsrState = {1'b0, lfsrState[31:1]} ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
    end
    return value;
endfunction

// ************************************************************
// Reference memory
// ************************************************************

logic [7:0] modelMem [ModelDepth];

function automatic void modelClear();
    for (int i = 0; i < ModelDepth; i++) begin
        modelMem[i] = 8'h00;
    end
endfunction

// Little-endian, zero-extended, wraps at the top of memory
function automatic logic [WordW-1:0] modelRead(input logic [AddrBits-1:0] addr,
                                               input logic [2:0] n);
    logic [WordW-1:0] word;
    word = '0;
    for (int i = 0; i < int'(n); i++) begin
        word[8*i +: 8] = modelMem[addr + AddrBits'(i)];
    end
    return word;
endfunction

function automatic void modelWrite(input logic [AddrBits-1:0] addr, input logic [2:0] n,
                                   input logic [WordW-1:0] wr);
    for (int i = 0; i < int'(n); i++) begin
        modelMem[addr + AddrBits'(i)] = wr[8*i +: 8];
    end
endfunction

task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        errorCount++;
        $display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
endtask

task automatic reportFailure(input string msg);
    errorCount++;
    $display("Failure at %0t: %s", $time, msg);
endtask

`endif

// ==== testbench/memSubsystemTb.sv ====
`timescale 1ns/1ps

module memSubsystemTb import memSysPkg::*; ();

    localparam int AddrBits    = 10;
    localparam int ModelDepth  = 1 << AddrBits;
    localparam int ClkPeriod   = 40;
    localparam int ResetCycles = 8;
    localparam int NumOps      = 400;
    localparam int CyclesPerOp = 20;
    localparam int OpLimit     = 200;
    localparam int TimeoutNs   = NumOps * CyclesPerOp * ClkPeriod;

    `include "tbModel.svh"

    typedef struct packed {
        logic                useFetch;
        logic                useData;
        logic                isStore;
        logic [2:0]          nBytes;
        logic [AddrBits-1:0] fetchAddr;
        logic [AddrBits-1:0] dataAddr;
        logic [WordW-1:0]    wr;
    } opDesc_t;

    logic                clk = 1'b0;
    logic                rstN;
    logic                fetchEn;
    logic [AddrBits-1:0] fetchAddr;
    logic                dataEn;
    logic                dataStore;
    accLen_t             dataLen;
    logic [AddrBits-1:0] dataAddr;
    logic [WordW-1:0]    dataWr;
    logic                flush;
    logic                ioStall;
    logic                fetchDone;
    logic [WordW-1:0]    fetchInst;
    logic                dataDone;
    logic [WordW-1:0]    dataRd;

    // Per-operation state
    opDesc_t             op;
    int                  cyc;
    int                  stallAt;
    int                  stallLen;
    int                  flushAt;
    logic                fetchPending;
    logic                dataPending;
    logic                flushHeld;
    logic                stalled;
    logic [WordW-1:0]    expFetch;
    logic [WordW-1:0]    expData;

    always #(ClkPeriod / 2) clk = ~clk;

    memSubsystem #(.AddrBits(AddrBits)) i_dut (
        .clk         (clk),
        .i_rstN      (rstN),
        .i_fetchEn   (fetchEn),
        .i_fetchAddr (fetchAddr),
        .i_dataEn    (dataEn),
        .i_dataStore (dataStore),
        .i_dataLen   (dataLen),
        .i_dataAddr  (dataAddr),
        .i_dataWr    (dataWr),
        .i_flush     (flush),
        .i_ioStall   (ioStall),
        .o_fetchDone (fetchDone),
        .o_fetchInst (fetchInst),
        .o_dataDone  (dataDone),
        .o_dataRd    (dataRd)
    );

    // ************************************************************
    // Stimulus
    // ************************************************************

    // Mostly a small window so stores and loads overlap
    function automatic logic [AddrBits-1:0] drawAddr();
        if (randBits(2) == 32'd0) begin
            return AddrBits'(randBits(AddrBits));
        end
        return AddrBits'(randBits(6));
    endfunction

    function automatic opDesc_t drawOp();
        opDesc_t    d;
        logic [1:0] kind;
        logic [1:0] lenSel;
        kind        = 2'(randBits(2));
        lenSel      = 2'(randBits(2));
        d.useFetch  = (kind == 2'd0) || (kind == 2'd3);
        d.useData   = (kind != 2'd0);
        d.isStore   = (kind == 2'd2) || ((kind == 2'd3) && (randBits(1) == 32'd1));
        d.nBytes    = (lenSel == 2'd0) ? 3'd1 : (lenSel == 2'd1) ? 3'd2 : 3'd4;
        d.fetchAddr = drawAddr();
        d.dataAddr  = drawAddr();
        d.wr        = randBits(32);
        return d;
    endfunction

    task automatic checkIdle();
        repeat (10) begin
            @(negedge clk);
            if (fetchDone || dataDone) begin
                reportFailure("done pulsed after reset with no request open");
            end
        end
    endtask

    task automatic runOperation();
        int latency;
        op       = drawOp();
        stallAt  = (randBits(2) == 32'd0) ? int'(randBits(3)) : -1;
        stallLen = 1 + int'(randBits(3));
        flushAt  = (op.useFetch && randBits(3) == 32'd0) ? int'(randBits(3)) : -1;
        latency  = int'(op.nBytes) + (op.isStore ? 1 : 2);

        // Data wins arbitration, so a store lands before the fetch reads
        if (op.useData && op.isStore) begin
            modelWrite(op.dataAddr, op.nBytes, op.wr);
        end
        expData      = modelRead(op.dataAddr, op.nBytes);
        expFetch     = modelRead(op.fetchAddr, 3'd4);
        fetchPending = op.useFetch;
        dataPending  = op.useData;
        flushHeld    = 1'b0;
        stalled      = 1'b0;
        cyc          = 0;

        forever begin
            @(posedge clk);
            if (!dataPending) dataEn <= 1'b0;
            if (!fetchPending) fetchEn <= 1'b0;
            if (cyc == 0) begin
                fetchEn   <= op.useFetch;
                fetchAddr <= op.fetchAddr;
                dataEn    <= op.useData;
                dataStore <= op.isStore;
                dataLen   <= accLen_t'(op.nBytes);
                dataAddr  <= op.dataAddr;
                dataWr    <= op.wr;
            end
            if (flushHeld) begin
                flush    <= 1'b0;
                flushHeld = 1'b0;
            end
            if (stallAt >= 0 && cyc >= stallAt && cyc < stallAt + stallLen) begin
                ioStall <= 1'b1;
                stalled  = 1'b1;
            end else begin
                ioStall <= 1'b0;
            end
            // A flushed fetch must never report done
            if (fetchPending && cyc == flushAt) begin
                flush       <= 1'b1;
                fetchPending = 1'b0;
                flushHeld    = 1'b1;
            end

            @(negedge clk);
            if (ioStall && (fetchDone || dataDone)) begin
                reportFailure("done pulsed while the stall was high");
            end
            if (dataDone) begin
                if (!dataPending) begin
                    reportFailure("o_dataDone pulsed with no data request open");
                end else begin
                    if (!op.isStore) checkValue("o_dataRd", dataRd, expData);
                    if (!stalled) checkValue("o_dataDone latency", cyc, latency);
                    dataPending = 1'b0;
                end
            end
            if (fetchDone) begin
                if (!fetchPending) begin
                    reportFailure("o_fetchDone pulsed with no fetch open, or after a flush");
                end else begin
                    checkValue("o_fetchInst", fetchInst, expFetch);
                    if (dataPending) reportFailure("fetch finished before the data request");
                    if (!stalled && !op.useData) begin
                        checkValue("o_fetchDone latency", cyc, WordW / 8 + 2);
                    end
                    fetchPending = 1'b0;
                end
            end
            if (!fetchPending && !dataPending) break;
            if (cyc >= OpLimit) begin
                reportFailure("request got no done within the cycle limit");
                break;
            end
            cyc++;
        end

        @(posedge clk);
        fetchEn <= 1'b0;
        dataEn  <= 1'b0;
        flush   <= 1'b0;
        ioStall <= 1'b0;
    endtask

    // ************************************************************
    // Main sequence and watchdog
    // ************************************************************

    initial begin
        rstN      = 1'b0;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        dataEn    = 1'b0;
        dataStore = 1'b0;
        dataLen   = Len1;
        dataAddr  = '0;
        dataWr    = '0;
        flush     = 1'b0;
        ioStall   = 1'b0;
        modelClear();
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        checkIdle();
        for (int i = 0; i < NumOps; i++) begin
            runOperation();
            repeat (randBits(2)) @(posedge clk);
        end
        $display("Run complete, %0d operations, %0d errors", NumOps, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TimeoutNs);
        $display("Timeout after %0d ns, run did not finish, %0d errors so far",
                 TimeoutNs, errorCount);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== memSubsystem.f ====
+incdir+testbench
design/memSysPkg.sv
design/byteRam.sv
design/memArbiter.sv
design/byteSequencer.sv
design/memSubsystem.sv
testbench/memSubsystemTb.sv

// ==== Makefile ====
TOP := memSubsystemTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f memSubsystem.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
